// ==== src/remainder_consts.svh ====
/*
 * width and step-count macros for the signed remainder unit
 *   operand word width
 *   internal long width, one extra bit of range
 *   number of division steps and the step counter width
 */

`ifndef REMAINDER_CONSTS_SVH
`define REMAINDER_CONSTS_SVH

// operand and result width
`define REM_WORD_WIDTH 8

// one extra bit so the most negative dividend can reach zero
`define REM_LONG_WIDTH (`REM_WORD_WIDTH + 1)

// one division step per bit of the long width
`define REM_STEPS `REM_LONG_WIDTH

// counter runs from REM_STEPS-1 down to zero
`define REM_STEPS_WIDTH $clog2(`REM_STEPS)

`endif

// ==== src/remainder_pkg.sv ====
/*
 * shared types for the signed remainder unit
 *   word_t  signed operand and result word
 *   long_t  internal remainder, divisor and increment value
 *   step_t  division step counter
 *   state_t control FSM state
 */

`include "remainder_consts.svh"

package remainder_pkg;

    // signed operand at the top-level ports
    typedef logic signed [`REM_WORD_WIDTH-1:0] word_t;

    // internal values carry one extra bit of range
    typedef logic [`REM_LONG_WIDTH-1:0] long_t;

    // down-counter over the division steps
    typedef logic [`REM_STEPS_WIDTH-1:0] step_t;

    // LOAD -> CALC -> DONE -> LOAD
    // 2'b01 is never entered
    typedef enum logic [1:0] {
        LOAD = 2'b00,
        CALC = 2'b10,
        DONE = 2'b11
    } state_t;

endpackage

// ==== src/remainder_control.sv ====
/*
 * control path of the signed remainder unit
 *   LOAD/CALC/DONE state register
 *   step down-counter
 *   input and output handshake levels
 *   load, step and first_step strobes for the data path
 */

`include "remainder_consts.svh"

module remainder_control (
    input  logic clock,
    input  logic reset,
    input  logic input_valid,
    input  logic output_ready,
    output logic input_ready,
    output logic output_valid,
    output logic load,
    output logic step,
    output logic first_step
);

    remainder_pkg::state_t state;
    remainder_pkg::state_t state_next;
    remainder_pkg::step_t  count;

    logic last_step;
    logic output_transfer;

    // ready and valid come only from the state, never from each other
    assign input_ready  = (state == remainder_pkg::LOAD);
    assign output_valid = (state == remainder_pkg::DONE);

    // handshake events
    assign load            = input_ready && input_valid;
    assign output_transfer = output_valid && output_ready;

    // one division step per CALC cycle
    assign step = (state == remainder_pkg::CALC);

    // the counter starts high and ends at zero
    assign first_step = step && (count == remainder_pkg::step_t'(`REM_STEPS - 1));
    assign last_step  = step && (count == '0);

    // next state, the three events never overlap
    always_comb begin
        state_next = state;
        if (load) begin
            state_next = remainder_pkg::CALC;
        end else if (last_step) begin
            state_next = remainder_pkg::DONE;
        end else if (output_transfer) begin
            state_next = remainder_pkg::LOAD;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= remainder_pkg::LOAD;
        end else begin
            state <= state_next;
        end
    end

    // step counter
    // reloads on the input transfer, counts down while calculating
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= remainder_pkg::step_t'(`REM_STEPS - 1);
        end else if (step) begin
            count <= count - 1'b1;
        end
    end

    // a result is never offered while new operands are being taken
    handshake_exclusive: assert property (
        @(posedge clock) disable iff (reset)
        !(input_ready && output_valid)
    );

    // the unused encoding must stay unreachable
    state_legal: assert property (
        @(posedge clock) disable iff (reset)
        state != 2'b01
    );

endmodule

// ==== src/divisor_shifter.sv ====
/*
 * divisor side of the signed remainder unit
 *   sign-extended divisor register, shifted right each step
 *   remainder increment built from the shifted-out divisor bits
 *   increment validity check
 *   divide-by-zero flag
 */

`include "remainder_consts.svh"

module divisor_shifter (
    input  logic                  clock,
    input  logic                  reset,
    input  remainder_pkg::word_t  divisor,
    input  logic                  load,
    input  logic                  step,
    input  logic                  first_step,
    output remainder_pkg::long_t  increment,
    output logic                  increment_valid,
    output logic                  divisor_sign,
    output logic                  divide_by_zero
);

    remainder_pkg::long_t divisor_long;
    remainder_pkg::long_t divisor_reg;
    remainder_pkg::long_t increment_reg;

    logic all_sign_bits;
    logic divisor_is_zero;

    // sign extension into the extra bit of range
    assign divisor_long = {divisor[`REM_WORD_WIDTH-1], divisor};

    // divisor and increment registers
    // the load already performs the first shift
    always_ff @(posedge clock) begin
        if (load) begin
            divisor_reg   <= {divisor_long[`REM_LONG_WIDTH-1],
                              divisor_long[`REM_LONG_WIDTH-1:1]};
            increment_reg <= {divisor_long[0], {`REM_WORD_WIDTH{1'b0}}};
        end else if (step) begin
            // arithmetic shift right, sign bit copied by hand
            divisor_reg   <= {divisor_reg[`REM_LONG_WIDTH-1],
                              divisor_reg[`REM_LONG_WIDTH-1:1]};
            // divisor lsb moves into the increment msb
            increment_reg <= {divisor_reg[0], increment_reg[`REM_LONG_WIDTH-1:1]};
        end
    end

    // sign of the divisor as loaded
    always_ff @(posedge clock) begin
        if (load) begin
            divisor_sign <= divisor_long[`REM_LONG_WIDTH-1];
        end
    end

    assign increment = increment_reg;

    // increment is meaningful only once every non-sign bit has left the divisor
    assign all_sign_bits = divisor_sign ? (divisor_reg == '1) : (divisor_reg == '0);

    // and once enough bits are in for its sign to match the divisor's
    assign increment_valid = all_sign_bits
                          && (increment_reg[`REM_LONG_WIDTH-1] == divisor_sign);

    // undo the load-time shift to see the original divisor
    assign divisor_is_zero =
        ({divisor_reg[`REM_WORD_WIDTH-1:0], increment_reg[`REM_LONG_WIDTH-1]} == '0);

    // sampled at the first step, held until the next division's first step
    always_ff @(posedge clock) begin
        if (reset) begin
            divide_by_zero <= 1'b0;
        end else if (first_step) begin
            divide_by_zero <= divisor_is_zero;
        end
    end

    // no load may arrive while the division steps are running
    sign_stable_in_calc: assert property (
        @(posedge clock) disable iff (reset)
        (step && !first_step) |-> $stable(divisor_sign)
    );

endmodule

// ==== src/remainder_accumulator.sv ====
/*
 * dividend side of the signed remainder unit
 *   remainder register, loaded with the sign-extended dividend
 *   single-cycle add or subtract of the increment
 *   rejection of steps that overflow or cross zero
 *   truncation back to word width
 */

`include "remainder_consts.svh"

module remainder_accumulator (
    input  logic                  clock,
    input  logic                  reset,
    input  remainder_pkg::word_t  dividend,
    input  logic                  load,
    input  logic                  step,
    input  remainder_pkg::long_t  increment,
    input  logic                  increment_valid,
    input  logic                  divisor_sign,
    output remainder_pkg::word_t  remainder
);

    remainder_pkg::long_t dividend_long;
    remainder_pkg::long_t remainder_reg;
    remainder_pkg::long_t operand_b;
    remainder_pkg::long_t sum;

    logic dividend_sign;
    logic subtract;
    logic overflow;
    logic sum_valid;
    logic accept;

    // sign extension into the extra bit of range
    assign dividend_long = {dividend[`REM_WORD_WIDTH-1], dividend};

    // matching signs means the increment points away from zero, so subtract
    assign subtract = (divisor_sign == dividend_sign);

    // subtraction as addition of the inverted operand plus one
    assign operand_b = subtract ? ~increment : increment;
    assign sum       = remainder_reg + operand_b + {{(`REM_LONG_WIDTH-1){1'b0}}, subtract};

    // signed overflow when equal-signed operands give a result of the other sign
    assign overflow = (remainder_reg[`REM_LONG_WIDTH-1] == operand_b[`REM_LONG_WIDTH-1])
                   && (sum[`REM_LONG_WIDTH-1] != remainder_reg[`REM_LONG_WIDTH-1]);

    // result stays on the dividend's side of zero, or lands on zero
    assign sum_valid = ((sum[`REM_LONG_WIDTH-1] == dividend_sign) && !overflow)
                    || (sum == '0);

    // a rejected step leaves the remainder alone
    assign accept = step && increment_valid && sum_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            remainder_reg <= '0;
            dividend_sign <= 1'b0;
        end else if (load) begin
            remainder_reg <= dividend_long;
            dividend_sign <= dividend_long[`REM_LONG_WIDTH-1];
        end else if (accept) begin
            remainder_reg <= sum;
        end
    end

    // magnitude is below the divisor's, so the extra bit is only sign
    assign remainder = remainder_reg[`REM_WORD_WIDTH-1:0];

    // the remainder only ever moves toward zero, never past it
    remainder_sign_kept: assert property (
        @(posedge clock) disable iff (reset)
        step |=> ((remainder_reg == '0)
              || (remainder_reg[`REM_LONG_WIDTH-1] == dividend_sign))
    );

endmodule

// ==== src/remainder_signed.sv ====
/*
 * signed integer remainder unit, top level
 *   control path FSM and step counter
 *   divisor shifter feeding the increment
 *   remainder accumulator holding the result
 */

module remainder_signed (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  input_valid,
    output logic                  input_ready,
    input  remainder_pkg::word_t  dividend,
    input  remainder_pkg::word_t  divisor,
    output logic                  output_valid,
    input  logic                  output_ready,
    output remainder_pkg::word_t  remainder,
    output logic                  divide_by_zero
);

    // strobes from the control path
    logic load;
    logic step;
    logic first_step;

    // operands from the shifter to the accumulator
    remainder_pkg::long_t increment;
    logic                 increment_valid;
    logic                 divisor_sign;

    remainder_control control (
        .clock        (clock),
        .reset        (reset),
        .input_valid  (input_valid),
        .output_ready (output_ready),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .load         (load),
        .step         (step),
        .first_step   (first_step)
    );

    divisor_shifter shifter (
        .clock           (clock),
        .reset           (reset),
        .divisor         (divisor),
        .load            (load),
        .step            (step),
        .first_step      (first_step),
        .increment       (increment),
        .increment_valid (increment_valid),
        .divisor_sign    (divisor_sign),
        .divide_by_zero  (divide_by_zero)
    );

    remainder_accumulator accumulator (
        .clock           (clock),
        .reset           (reset),
        .dividend        (dividend),
        .load            (load),
        .step            (step),
        .increment       (increment),
        .increment_valid (increment_valid),
        .divisor_sign    (divisor_sign),
        .remainder       (remainder)
    );

endmodule

// ==== test/remainder_tb.sv ====
/*
 * directed testbench for the signed remainder unit
 *   clock, reset and operand driving on the falling edge
 *   compare tasks for remainder, flag and handshake levels
 *   tests for sign cases, zero divisors, range edges, random pairs,
 *   back-pressure and reset during a calculation
 */

`include "remainder_consts.svh"

module remainder_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // cycles allowed for any single wait
    localparam int WAIT_LIMIT = 4 * `REM_STEPS + 20;

    logic                 clock;
    logic                 reset;
    logic                 input_valid;
    logic                 input_ready;
    remainder_pkg::word_t dividend;
    remainder_pkg::word_t divisor;
    logic                 output_valid;
    logic                 output_ready;
    remainder_pkg::word_t remainder;
    logic                 divide_by_zero;

    remainder_signed i_dut (
        .clock          (clock),
        .reset          (reset),
        .input_valid    (input_valid),
        .input_ready    (input_ready),
        .dividend       (dividend),
        .divisor        (divisor),
        .output_valid   (output_valid),
        .output_ready   (output_ready),
        .remainder      (remainder),
        .divide_by_zero (divide_by_zero)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic stop_with_fail();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input remainder_pkg::word_t expected,
                              input remainder_pkg::word_t actual);
        if (actual !== expected) begin
            $display("Error at time %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            stop_with_fail();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at time %0t: %s expected %b, actual %b",
                     $time, name, expected, actual);
            stop_with_fail();
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at time %0t: handshake %s expected %b, actual %b",
                     $time, name, expected, actual);
            stop_with_fail();
        end
    endtask

    // names the missing event and the FSM state where the unit got stuck
    task automatic report_timeout(input string what);
        remainder_pkg::state_t state_seen;
        state_seen = i_dut.control.state;
        $display("Timeout at time %0t: %s did not happen within %0d cycles, FSM in %s",
                 $time, what, WAIT_LIMIT, state_seen.name());
        stop_with_fail();
    endtask

    // truncating remainder, or the dividend itself for a zero divisor
    function automatic remainder_pkg::word_t expected_remainder(
        input remainder_pkg::word_t a, input remainder_pkg::word_t b);
        int a_int;
        int b_int;
        a_int = a;
        b_int = b;
        if (b_int == 0) begin
            return a;
        end
        return remainder_pkg::word_t'(a_int % b_int);
    endfunction

    // waits for input_ready, then holds valid over one rising edge
    task automatic send_operands(input remainder_pkg::word_t a, input remainder_pkg::word_t b);
        int waited;
        waited = 0;
        while (!input_ready) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("input_ready");
            end
        end
        input_valid = 1'b1;
        dividend    = a;
        divisor     = b;
        @(negedge clock);
        input_valid = 1'b0;
    endtask

    // transfer edge counts as the first edge
    task automatic start_division(input remainder_pkg::word_t a, input remainder_pkg::word_t b);
        int edges;
        send_operands(a, b);
        edges = 1;
        while (!output_valid) begin
            @(negedge clock);
            edges++;
            if (edges > WAIT_LIMIT) begin
                report_timeout("output_valid");
            end
        end
        if (edges != `REM_STEPS + 1) begin
            $display("Error at time %0t: latency expected %0d, actual %0d",
                     $time, `REM_STEPS + 1, edges);
            stop_with_fail();
        end
    endtask

    // checks the result, holds it for hold cycles, then takes it
    task automatic finish_division(input remainder_pkg::word_t a, input remainder_pkg::word_t b,
                                   input int hold);
        remainder_pkg::word_t exp_rem;
        logic                 exp_flag;
        int                   i;
        exp_rem  = expected_remainder(a, b);
        exp_flag = (b == 0);
        check_word("remainder", exp_rem, remainder);
        check_flag("divide_by_zero", exp_flag, divide_by_zero);
        for (i = 0; i < hold; i++) begin
            @(negedge clock);
            check_level("output_valid", 1'b1, output_valid);
            check_level("input_ready", 1'b0, input_ready);
            check_word("remainder", exp_rem, remainder);
            check_flag("divide_by_zero", exp_flag, divide_by_zero);
        end
        output_ready = 1'b1;
        @(negedge clock);
        output_ready = 1'b0;
        // result taken, unit ready for the next operands
        check_level("input_ready", 1'b1, input_ready);
        check_level("output_valid", 1'b0, output_valid);
    endtask

    task automatic run_division(input remainder_pkg::word_t a, input remainder_pkg::word_t b);
        start_division(a, b);
        finish_division(a, b, 0);
    endtask

    task automatic reference_cases();
        run_division(22, 7);
        run_division(-22, 7);
        run_division(22, -7);
        run_division(-22, -7);
        run_division(7, 22);
        run_division(-7, 22);
        run_division(7, -22);
        run_division(-7, -22);
    endtask

    // a nonzero division after each zero divisor must clear the flag
    task automatic zero_divisors();
        run_division(0, 0);
        run_division(22, 0);
        run_division(5, 3);
        run_division(-22, 0);
        run_division(-22, 5);
    endtask

    task automatic range_edges();
        run_division(-128, 1);
        run_division(-128, -1);
        run_division(-128, 127);
        run_division(127, -128);
        run_division(-1, -128);
    endtask

    // about one divisor in eight is zero
    task automatic random_pairs();
        remainder_pkg::word_t a;
        remainder_pkg::word_t b;
        int                   n;
        for (n = 0; n < 200; n++) begin
            a = remainder_pkg::word_t'($urandom());
            b = remainder_pkg::word_t'($urandom());
            if ($urandom_range(7, 0) == 0) begin
                b = '0;
            end
            run_division(a, b);
        end
    endtask

    task automatic back_pressure();
        int hold;
        hold = $urandom_range(20, 1);
        start_division(-100, 9);
        finish_division(-100, 9, hold);
        hold = $urandom_range(20, 1);
        start_division(45, 0);
        finish_division(45, 0, hold);
    endtask

    // the interrupted division is past its first step, so the flag is already set
    task automatic reset_during_calc();
        send_operands(22, 0);
        repeat (3) @(negedge clock);
        // still calculating, with the flag raised
        check_level("input_ready", 1'b0, input_ready);
        check_level("output_valid", 1'b0, output_valid);
        check_flag("divide_by_zero", 1'b1, divide_by_zero);
        reset = 1'b1;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        check_level("input_ready", 1'b1, input_ready);
        check_level("output_valid", 1'b0, output_valid);
        check_flag("divide_by_zero", 1'b0, divide_by_zero);
        run_division(-22, 7);
    endtask

    initial begin
        reset        = 1'b1;
        input_valid  = 1'b0;
        dividend     = '0;
        divisor      = '0;
        output_ready = 1'b0;
        void'($urandom(32'ha8d03201));

        repeat (5) @(negedge clock);
        reset = 1'b0;

        // levels straight after reset
        check_level("input_ready", 1'b1, input_ready);
        check_level("output_valid", 1'b0, output_valid);
        check_flag("divide_by_zero", 1'b0, divide_by_zero);

        reference_cases();
        zero_divisors();
        range_edges();
        random_pairs();
        back_pressure();
        reset_during_calc();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/remainder_pkg.sv
src/remainder_control.sv
src/divisor_shifter.sv
src/remainder_accumulator.sv
src/remainder_signed.sv
test/remainder_tb.sv

// ==== Makefile ====
# Verilator build for the signed remainder unit
# variables below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= remainder_tb
RTL_TOP   ?= remainder_signed
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

FAIL_MSG ?= Simulation finished: FAIL
PASS_MSG ?= Simulation finished: PASS

SOURCES := $(wildcard src/*.sv src/*.svh test/*.sv) $(FILELIST)
BIN     := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BIN): $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
